//--- Bender.yml
package:
  name: lsel

sources:
  # Design sources in compile order
  - files:
      - design/lsel_pkg.sv
      - design/mem_reset_sync.sv
      - design/rf_24x9_model.sv
      - design/lsel_mem_rf_pg_24x9.sv
      - design/lsel_cmd_decode.sv
      - design/lsel_scan.sv
      - design/lsel_top.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - tests/lsel_props.sv
      - tests/lsel_tb.sv

//--- design/lsel_cmd_decode.sv
/*
 * List selector command decoder
 * Turns accepted commands into registered writes on the record file.
 * After reset and after every power-up it first writes zeros to all 24
 * entries, holding init_busy high until the sweep is over.
 */

`timescale 1ns/1ps

module lsel_cmd_decode
    import lsel_pkg::*;
(
     input  logic               clk
    ,input  logic               rst_n
    ,input  logic               cmd_valid
    ,input  lsel_cmd_e          cmd_op
    ,input  logic [lsel_aw-1:0] cmd_addr
    ,input  logic [lsel_dw-1:0] cmd_data
    ,input  logic               pwr_off
    ,output logic               we
    ,output logic [lsel_aw-1:0] waddr
    ,output logic [lsel_dw-1:0] wdata
    ,output logic               init_busy
);

    logic               pwr_off_q;
    logic               init_run;
    logic [lsel_aw-1:0] init_cnt;
    logic               init_last;
    logic               cmd_take;
    logic [lsel_dw-1:0] cmd_wdata;

    // Commands are dropped while the file is being cleared
    assign cmd_take  = cmd_valid && !init_busy;
    assign init_last = (init_cnt == lsel_aw'(lsel_depth - 1));

    // Record written for each opcode
    always_comb begin
        case (cmd_op)
            CMD_WRITE:  cmd_wdata = cmd_data;
            // Enable flag forced on, tag taken from the low byte
            CMD_ENABLE: cmd_wdata = {1'b1, cmd_data[lsel_en_bit-1:0]};
            default:    cmd_wdata = '0;
        endcase
    end

    // ------------------------------------------------------------
    // Init sequencer and write strobe
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwr_off_q <= 1'b1;
            init_busy <= 1'b1;
            init_run  <= 1'b0;
            init_cnt  <= '0;
            we        <= 1'b0;
        end else begin
            pwr_off_q <= pwr_off;
            we        <= 1'b0;
            if (pwr_off) begin
                // Array is down, wait for power to come back
                init_busy <= 1'b1;
                init_run  <= 1'b0;
                init_cnt  <= '0;
            end else if (pwr_off_q) begin
                // Power just came up, start the clear sweep at entry 0
                init_run <= 1'b1;
                init_cnt <= '0;
            end else if (init_run) begin
                we       <= 1'b1;
                init_cnt <= init_cnt + 1'b1;
                if (init_last) begin
                    init_run  <= 1'b0;
                    init_busy <= 1'b0;
                end
            end else if (cmd_take && (cmd_op != CMD_NOP)) begin
                we <= 1'b1;
            end
        end
    end

    // Write address and data for the strobe above, from the sweep or the command
    always_ff @(posedge clk) begin
        if (init_run) begin
            waddr <= init_cnt;
            wdata <= '0;
        end else if (cmd_take) begin
            waddr <= cmd_addr;
            wdata <= cmd_wdata;
        end
    end

endmodule

//--- design/lsel_mem_rf_pg_24x9.sv
/*
 * Power-gated 24x9 record file wrapper
 * Puts the IP reset through a synchronizer on the read clock and passes
 * the write port, read port, isolation and power controls to the array.
 * The power acknowledge comes back from the array a cycle late.
 */

`timescale 1ns/1ps

module lsel_mem_rf_pg_24x9
    import lsel_pkg::*;
(
     input  logic               wclk
    ,input  logic               we
    ,input  logic [lsel_aw-1:0] waddr
    ,input  logic [lsel_dw-1:0] wdata

    ,input  logic               rclk
    ,input  logic               re
    ,input  logic [lsel_aw-1:0] raddr
    ,output logic [lsel_dw-1:0] rdata

    // Power control
    ,input  logic               pgcb_isol_en
    ,input  logic               pwr_enable_b_in
    ,output logic               pwr_enable_b_out

    ,input  logic               ip_reset_b
);

    // Reset as seen by the array, released on rclk
    logic ip_reset_b_sync;

    // ------------------------------------------------------------
    // IP reset synchronizer
    // ------------------------------------------------------------
    mem_reset_sync i_ip_reset_b_sync (
         .clk        (rclk)
        ,.rst_n      (ip_reset_b)
        ,.rst_n_sync (ip_reset_b_sync)
    );

    // ------------------------------------------------------------
    // Array model, stands in for the hard macro
    // ------------------------------------------------------------
    rf_24x9_model i_rf (
         .wclk             (wclk)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.rclk             (rclk)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.ip_reset_b       (ip_reset_b_sync)
        ,.isol_en          (pgcb_isol_en)
        ,.pwr_enable_b     (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

endmodule

//--- design/lsel_pkg.sv
/*
 * List selector shared definitions
 * Sizes of the 24-queue record file, the command opcodes taken by the
 * command decoder and the state encoding of the round-robin scanner.
 */

package lsel_pkg;

    // ------------------------------------------------------------
    // Record file geometry
    // ------------------------------------------------------------

    // Number of queues, one record per queue
    localparam int lsel_depth = 24;

    // Address width, enough for 24 entries
    localparam int lsel_aw = 5;

    // Record width: enable flag on top of an 8-bit payload tag
    localparam int lsel_dw = 9;

    // Position of the enable flag inside a record
    localparam int lsel_en_bit = 8;

    // ------------------------------------------------------------
    // Command and scanner encodings
    // ------------------------------------------------------------

    // Commands arriving with cmd_valid
    typedef enum logic [1:0] {
        CMD_NOP     = 2'd0,
        CMD_WRITE   = 2'd1,
        CMD_ENABLE  = 2'd2,
        CMD_DISABLE = 2'd3
    } lsel_cmd_e;

    // Scanner FSM states
    typedef enum logic [1:0] {
        SCAN_IDLE = 2'd0,
        SCAN_RUN  = 2'd1,
        SCAN_DONE = 2'd2
    } lsel_scan_e;

endpackage

//--- design/lsel_scan.sv
/*
 * List selector round-robin scanner
 * On an accepted request it reads the record file once per cycle from the
 * rotating pointer and checks each record a cycle later. The first enabled
 * record ends the scan and moves the pointer past it. After 24 records
 * without a hit the scan ends empty and the pointer stays.
 */

`timescale 1ns/1ps

module lsel_scan
    import lsel_pkg::*;
(
     input  logic                   clk
    ,input  logic                   rst_n
    ,input  logic                   sel_req
    ,input  logic                   init_busy
    ,output logic                   re
    ,output logic [lsel_aw-1:0]     raddr
    ,input  logic [lsel_dw-1:0]     rdata
    ,output logic                   sel_done
    ,output logic                   sel_found
    ,output logic [lsel_aw-1:0]     sel_qid
    ,output logic [lsel_en_bit-1:0] sel_tag
);

    lsel_scan_e         state;
    logic [lsel_aw-1:0] ptr;
    logic [lsel_aw-1:0] iss_cnt;
    logic [lsel_aw-1:0] chk_cnt;
    logic [lsel_aw-1:0] chk_addr;
    logic               rd_vld;
    logic               req_take;
    logic               hit;
    logic               last_chk;
    logic               issue_next;

    // Next queue index, wrapping at 24
    function automatic logic [lsel_aw-1:0] addr_inc(input logic [lsel_aw-1:0] a);
        return (a == lsel_aw'(lsel_depth - 1)) ? '0 : a + 1'b1;
    endfunction

    // Requests only count while idle and the file holds valid records
    assign req_take = sel_req && (state == SCAN_IDLE) && !init_busy;

    // Record returned this cycle belongs to chk_addr
    assign hit      = (state == SCAN_RUN) && rd_vld && rdata[lsel_en_bit];
    assign last_chk = (state == SCAN_RUN) && rd_vld && (chk_cnt == lsel_aw'(lsel_depth - 1));

    // Keep reading until a hit, the last check, or 24 reads issued
    assign issue_next = (state == SCAN_RUN) && !hit && !last_chk &&
                        (iss_cnt != lsel_aw'(lsel_depth));

    // ------------------------------------------------------------
    // Scanner FSM and counters
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SCAN_IDLE;
            re        <= 1'b0;
            rd_vld    <= 1'b0;
            iss_cnt   <= '0;
            chk_cnt   <= '0;
            ptr       <= '0;
            sel_done  <= 1'b0;
            sel_found <= 1'b0;
        end else begin
            // Read data shows up the cycle after the read
            rd_vld   <= re;
            sel_done <= 1'b0;
            case (state)
                SCAN_IDLE: begin
                    if (req_take) begin
                        state   <= SCAN_RUN;
                        re      <= 1'b1;
                        iss_cnt <= 5'd1;
                        chk_cnt <= '0;
                    end
                end
                SCAN_RUN: begin
                    if (rd_vld) begin
                        chk_cnt <= chk_cnt + 1'b1;
                    end
                    if (hit || last_chk) begin
                        state     <= SCAN_DONE;
                        re        <= 1'b0;
                        sel_done  <= 1'b1;
                        sel_found <= hit;
                        if (hit) begin
                            ptr <= addr_inc(chk_addr);
                        end
                    end else begin
                        re <= issue_next;
                        if (issue_next) begin
                            iss_cnt <= iss_cnt + 1'b1;
                        end
                    end
                end
                // The read issued in the hit cycle lands here and is dropped
                default: begin
                    state <= SCAN_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // Read address pipeline and result payload
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (req_take) begin
            raddr <= ptr;
        end else if (issue_next) begin
            raddr <= addr_inc(raddr);
        end
        // Address travels alongside the read to tag the returned record
        if (re) begin
            chk_addr <= raddr;
        end
        if (hit) begin
            sel_qid <= chk_addr;
            sel_tag <= rdata[lsel_en_bit-1:0];
        end
    end

endmodule

//--- design/lsel_top.sv
/*
 * List selector top level
 * Command decoder writes the power-gated record file, the round-robin
 * scanner reads it. Both memory clocks come from the one system clock.
 */

`timescale 1ns/1ps

module lsel_top
    import lsel_pkg::*;
(
     input  logic                   clk
    ,input  logic                   rst_n

    // Command side
    ,input  logic                   cmd_valid
    ,input  lsel_cmd_e              cmd_op
    ,input  logic [lsel_aw-1:0]     cmd_addr
    ,input  logic [lsel_dw-1:0]     cmd_data
    ,output logic                   init_busy

    // Selection side
    ,input  logic                   sel_req
    ,output logic                   sel_done
    ,output logic                   sel_found
    ,output logic [lsel_aw-1:0]     sel_qid
    ,output logic [lsel_en_bit-1:0] sel_tag

    // Power control
    ,input  logic                   pwr_enable_b
    ,input  logic                   pgcb_isol_en
    ,output logic                   pwr_enable_b_out
);

    // Write port, owned by the decoder
    logic               we;
    logic [lsel_aw-1:0] waddr;
    logic [lsel_dw-1:0] wdata;

    // Read port, owned by the scanner
    logic               re;
    logic [lsel_aw-1:0] raddr;
    logic [lsel_dw-1:0] rdata;

    // ------------------------------------------------------------
    // Command decoder, restarts its clear sweep on power-up
    // ------------------------------------------------------------
    lsel_cmd_decode i_cmd_decode (
         .clk       (clk)
        ,.rst_n     (rst_n)
        ,.cmd_valid (cmd_valid)
        ,.cmd_op    (cmd_op)
        ,.cmd_addr  (cmd_addr)
        ,.cmd_data  (cmd_data)
        ,.pwr_off   (pwr_enable_b_out)
        ,.we        (we)
        ,.waddr     (waddr)
        ,.wdata     (wdata)
        ,.init_busy (init_busy)
    );

    // Record file
    lsel_mem_rf_pg_24x9 i_mem (
         .wclk             (clk)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.rclk             (clk)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.ip_reset_b       (rst_n)
    );

    // Round-robin scanner
    lsel_scan i_scan (
         .clk       (clk)
        ,.rst_n     (rst_n)
        ,.sel_req   (sel_req)
        ,.init_busy (init_busy)
        ,.re        (re)
        ,.raddr     (raddr)
        ,.rdata     (rdata)
        ,.sel_done  (sel_done)
        ,.sel_found (sel_found)
        ,.sel_qid   (sel_qid)
        ,.sel_tag   (sel_tag)
    );

endmodule

//--- design/mem_reset_sync.sv
/*
 * Memory reset synchronizer
 * Two-flop chain for the record file's IP reset. Assertion reaches the
 * output at once, release is delayed by two clock edges.
 */

`timescale 1ns/1ps

module mem_reset_sync (
     input  logic clk
    ,input  logic rst_n
    ,output logic rst_n_sync
);

    // Shift chain, a one enters from the bottom once reset is released
    logic [1:0] sync_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Reset goes straight through to the array
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // Second stage is the clean, synchronous release
    assign rst_n_sync = sync_q[1];

endmodule

//--- design/rf_24x9_model.sv
/*
 * Behavioral 24x9 two-port register file
 * One write port and one registered read port with one cycle of latency.
 * Models the power gating of the hard macro: while powered down the
 * contents are lost, writes are dropped and read data is zero. Isolation
 * clamps the read data on the way out.
 */

`timescale 1ns/1ps

module rf_24x9_model
    import lsel_pkg::*;
(
     input  logic               wclk
    ,input  logic               we
    ,input  logic [lsel_aw-1:0] waddr
    ,input  logic [lsel_dw-1:0] wdata
    ,input  logic               rclk
    ,input  logic               re
    ,input  logic [lsel_aw-1:0] raddr
    ,output logic [lsel_dw-1:0] rdata
    ,input  logic               ip_reset_b
    ,input  logic               isol_en
    ,input  logic               pwr_enable_b
    ,output logic               pwr_enable_b_out
);

    logic [lsel_dw-1:0] mem [lsel_depth];
    logic [lsel_dw-1:0] rdata_q;

    // Power state of the array, a delayed copy of the request
    // Comes out of reset powered down
    always_ff @(posedge rclk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            pwr_enable_b_out <= 1'b1;
        end else begin
            pwr_enable_b_out <= pwr_enable_b;
        end
    end

    // Write port
    // A powered-down array loses everything, so it is zeroed here
    always_ff @(posedge wclk) begin
        if (pwr_enable_b_out) begin
            for (int i = 0; i < lsel_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we && (waddr < lsel_aw'(lsel_depth))) begin
            mem[waddr] <= wdata;
        end
    end

    // Read port, out-of-range addresses return zero
    always_ff @(posedge rclk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            rdata_q <= '0;
        end else if (pwr_enable_b_out) begin
            rdata_q <= '0;
        end else if (re) begin
            rdata_q <= (raddr < lsel_aw'(lsel_depth)) ? mem[raddr] : '0;
        end
    end

    // Isolation clamp on the output
    assign rdata = isol_en ? '0 : rdata_q;

endmodule

//--- project.f
design/lsel_pkg.sv
design/mem_reset_sync.sv
design/rf_24x9_model.sv
design/lsel_mem_rf_pg_24x9.sv
design/lsel_cmd_decode.sv
design/lsel_scan.sv
design/lsel_top.sv
tests/lsel_props.sv
tests/lsel_tb.sv

//--- tests/lsel_props.sv
/*
 * List selector protocol checks
 * Concurrent assertions bound into the top level: done is a single-cycle
 * pulse, the file stays in init while powered down, and a selected queue
 * index is always in range.
 */

`timescale 1ns/1ps

module lsel_props
    import lsel_pkg::*;
(
     input  logic               clk
    ,input  logic               rst_n
    ,input  logic               sel_done
    ,input  logic               sel_found
    ,input  logic [lsel_aw-1:0] sel_qid
    ,input  logic               init_busy
    ,input  logic               pwr_enable_b_out
);

    // Result strobe never lasts two cycles
    done_is_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) sel_done |=> !sel_done
    ) else $error("sel_done high on two consecutive cycles");

    // Decoder sees the power acknowledge one edge late, so init follows a cycle on
    busy_while_off: assert property (
        @(posedge clk) disable iff (!rst_n) pwr_enable_b_out |=> init_busy
    ) else $error("init_busy low while the record file is powered down");

    // Only real queues can be reported
    qid_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) (sel_done && sel_found) |-> (sel_qid < lsel_depth)
    ) else $error("sel_qid out of range on a found result");

endmodule

bind lsel_top lsel_props i_lsel_props (.*);

//--- tests/lsel_tb.sv
/*
 * List selector testbench
 * Drives commands, selection requests and power controls into the top
 * level. Every selection is compared against a 24-entry reference file
 * and a reference round-robin pointer.
 */

`timescale 1ns/1ps

module lsel_tb
    import lsel_pkg::*;
();

    localparam int num_queues = 24;
    localparam int wait_limit = 200;

    logic               clk;
    logic               rst_n;
    logic               cmd_valid;
    lsel_cmd_e          cmd_op;
    logic [4:0]         cmd_addr;
    logic [8:0]         cmd_data;
    logic               sel_req;
    logic               pwr_enable_b;
    logic               pgcb_isol_en;
    logic               init_busy;
    logic               pwr_enable_b_out;
    logic               sel_done;
    logic               sel_found;
    logic [4:0]         sel_qid;
    logic [7:0]         sel_tag;

    // Reference record file and round-robin pointer
    logic [8:0]         ref_mem [num_queues];
    int                 ref_ptr;
    int                 seed;
    int                 checks;
    int                 errors;

    always #20 clk = ~clk;

    lsel_top i_lsel_top (
         .clk              (clk)
        ,.rst_n            (rst_n)
        ,.cmd_valid        (cmd_valid)
        ,.cmd_op           (cmd_op)
        ,.cmd_addr         (cmd_addr)
        ,.cmd_data         (cmd_data)
        ,.init_busy        (init_busy)
        ,.sel_req          (sel_req)
        ,.sel_done         (sel_done)
        ,.sel_found        (sel_found)
        ,.sel_qid          (sel_qid)
        ,.sel_tag          (sel_tag)
        ,.pwr_enable_b     (pwr_enable_b)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    // Inputs change and outputs are sampled 2 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic expect_value(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic give_up(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("Test failed");
        $finish;
    endtask

    task automatic report_test(input string name, input int start_errors);
        $display("%s finished with %0d errors", name, errors - start_errors);
    endtask

    task automatic wait_init();
        int n;
        n = 0;
        while (init_busy) begin
            if (n == wait_limit) give_up("init_busy to fall");
            step();
            n++;
        end
    endtask

    // Accepted only while the clear sweep is over, as the decoder does
    task automatic send_cmd(input lsel_cmd_e op, input int addr, input logic [8:0] data);
        bit taken;
        taken     = !init_busy;
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = 5'(addr);
        cmd_data  = data;
        step();
        cmd_valid = 1'b0;
        cmd_op    = CMD_NOP;
        if (taken && (addr < num_queues)) begin
            case (op)
                CMD_WRITE:   ref_mem[addr] = data;
                CMD_ENABLE:  ref_mem[addr] = {1'b1, data[7:0]};
                CMD_DISABLE: ref_mem[addr] = '0;
                default:     ;
            endcase
        end
        // One more edge and the record sits in the file
        step();
    endtask

    // First enabled queue from the pointer, the pointer moves past a hit
    task automatic predict_pick(output bit found, output int qid, output int tag);
        int q;
        found = 1'b0;
        qid   = 0;
        tag   = 0;
        // An isolated file reads as all zeros
        if (!pgcb_isol_en) begin
            for (int i = 0; (i < num_queues) && !found; i++) begin
                q = (ref_ptr + i) % num_queues;
                if (ref_mem[q][8]) begin
                    found = 1'b1;
                    qid   = q;
                    tag   = ref_mem[q][7:0];
                end
            end
        end
        if (found) ref_ptr = (qid + 1) % num_queues;
    endtask

    task automatic run_scan(input string what);
        bit exp_found;
        int exp_qid;
        int exp_tag;
        int n;
        predict_pick(exp_found, exp_qid, exp_tag);
        sel_req = 1'b1;
        step();
        sel_req = 1'b0;
        n = 0;
        while (!sel_done) begin
            if (n == wait_limit) give_up("sel_done");
            step();
            n++;
        end
        expect_value(sel_found, exp_found, {what, ": sel_found"});
        if (exp_found) begin
            expect_value(sel_qid, exp_qid, {what, ": sel_qid"});
            expect_value(sel_tag, exp_tag, {what, ": sel_tag"});
        end
        // Scanner passes through its done state before it is idle again
        step();
    endtask

    task automatic power_cycle();
        pwr_enable_b = 1'b1;
        step();
        expect_value(pwr_enable_b_out, 1, "pwr_enable_b_out after power-down");
        step();
        expect_value(init_busy, 1, "init_busy while powered down");
        // Contents are gone once the array loses power
        foreach (ref_mem[i]) ref_mem[i] = '0;
        repeat (3) step();
        pwr_enable_b = 1'b0;
        step();
        expect_value(pwr_enable_b_out, 0, "pwr_enable_b_out after power-up");
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------

    task automatic reset_and_init();
        int start;
        start = errors;
        expect_value(init_busy, 1, "init_busy after reset");
        expect_value(sel_done, 0, "sel_done after reset");
        wait_init();
        run_scan("empty file after reset");
        report_test("reset and init", start);
    endtask

    task automatic round_robin_order();
        int         qs [4] = '{3, 8, 15, 22};
        logic [7:0] tag;
        int         start;
        start = errors;
        foreach (qs[i]) begin
            tag = 8'($random(seed));
            send_cmd(CMD_ENABLE, qs[i], {1'b0, tag});
        end
        repeat (6) run_scan("round robin");
        report_test("round robin order", start);
    endtask

    task automatic remove_and_drop();
        int start;
        start = errors;
        // A plain write with the flag low removes a queue like a disable
        send_cmd(CMD_WRITE, 8, {1'b0, 8'h5a});
        send_cmd(CMD_DISABLE, 15, '0);
        repeat (3) run_scan("after write and disable");
        power_cycle();
        // Entry 0 is cleared early in the sweep, the sweep is still running
        repeat (10) step();
        expect_value(init_busy, 1, "init_busy during clear sweep");
        send_cmd(CMD_ENABLE, 0, 9'h0a5);
        wait_init();
        run_scan("command sent during init");
        report_test("remove and drop", start);
    endtask

    task automatic request_while_busy();
        bit exp_found;
        int exp_qid;
        int exp_tag;
        int dones;
        int start;
        start = errors;
        send_cmd(CMD_ENABLE, 5, {1'b0, 8'($random(seed))});
        send_cmd(CMD_ENABLE, 17, {1'b0, 8'($random(seed))});
        predict_pick(exp_found, exp_qid, exp_tag);
        sel_req = 1'b1;
        step();
        sel_req = 1'b0;
        step();
        // Second strobe reaches the scanner while it is still running
        sel_req = 1'b1;
        step();
        sel_req = 1'b0;
        dones = 0;
        for (int n = 0; n < 60; n++) begin
            if (sel_done) begin
                dones++;
                expect_value(sel_found, exp_found, "busy request: sel_found");
                expect_value(sel_qid, exp_qid, "busy request: sel_qid");
                expect_value(sel_tag, exp_tag, "busy request: sel_tag");
            end
            step();
        end
        expect_value(dones, 1, "sel_done count with a request during a scan");
        report_test("request while busy", start);
    endtask

    task automatic power_down_up();
        int start;
        start = errors;
        power_cycle();
        wait_init();
        repeat (2) run_scan("after power-up");
        report_test("power down and up", start);
    endtask

    task automatic isolation_clamp();
        int start;
        start = errors;
        send_cmd(CMD_ENABLE, 10, {1'b0, 8'($random(seed))});
        send_cmd(CMD_ENABLE, 20, {1'b0, 8'($random(seed))});
        pgcb_isol_en = 1'b1;
        step();
        repeat (2) run_scan("isolated");
        pgcb_isol_en = 1'b0;
        step();
        repeat (2) run_scan("after isolation release");
        report_test("isolation clamp", start);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        cmd_valid    = 1'b0;
        cmd_op       = CMD_NOP;
        cmd_addr     = '0;
        cmd_data     = '0;
        sel_req      = 1'b0;
        pwr_enable_b = 1'b0;
        pgcb_isol_en = 1'b0;
        seed         = 42;
        checks       = 0;
        errors       = 0;
        ref_ptr      = 0;
        foreach (ref_mem[i]) ref_mem[i] = '0;
        repeat (5) step();
        rst_n = 1'b1;
        reset_and_init();
        round_robin_order();
        remove_and_drop();
        request_while_busy();
        power_down_up();
        isolation_clamp();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
